// File: project.f
+incdir+logic
logic/cache_pkg.sv
logic/write_align.sv
logic/tag_store.sv
logic/data_store.sv
logic/cache_ctrl.sv
logic/cache_top.sv
dv/cache_props.sv
dv/cache_tb.sv

// File: run.sh
#!/bin/sh
# build and run the cache testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -f project.f --top-module cache_tb -o Vcache_tb

# the log decides pass or fail
./obj_dir/Vcache_tb 2>&1 | tee sim.log

if grep -q "ALL TESTS PASSED" sim.log; then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

// File: dv/cache_tb.sv
`include "cache_config.svh"

module cache_tb;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int MEM_LINES = 1 << (`CACHE_ADDR_W - `CACHE_OFFSET_W);
   localparam int CLK_PERIOD = 100;
   localparam int RESET_CYCLES = 8;

   // one row of the stimulus table
   typedef struct {
      string                  name;
      logic                   rw;
      cache_pkg::cache_addr_u addr;
      logic [3:0]             size;
      cache_pkg::line_t       wdata;
      logic                   expect_bus;
   } test_t;

   logic clk;
   logic rst_n;
   cache_pkg::cpu_req_t cpu_req;
   logic ready;
   cache_pkg::line_t rdata;
   cache_pkg::bus_req_t bus_req;
   cache_pkg::bus_rsp_t bus_rsp;

   // memory behind the bus
   cache_pkg::line_t mem [MEM_LINES];
   // memory with every processor write merged
   cache_pkg::line_t shadow [MEM_LINES];
   // expected tag state per index
   logic ref_valid [`CACHE_LINES];
   logic [`CACHE_TAG_W-1:0] ref_tag [`CACHE_LINES];
   // finished bus transfers, oldest first
   cache_pkg::bus_req_t bus_log [$];
   test_t tests [$];
   logic table_ready = 1'b0;

   cache_top DUT (
      .clk     (clk),
      .rst_n   (rst_n),
      .cpu_req (cpu_req),
      .ready   (ready),
      .rdata   (rdata),
      .bus_req (bus_req),
      .bus_rsp (bus_rsp)
   );

   initial
   begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   // memory answers each request after 0 to 5 cycles
   initial
   begin
      cache_pkg::bus_req_t req;
      int unsigned delay;
      bus_rsp = '0;
      forever
      begin
         @(negedge clk);
         bus_rsp.ready = 1'b0;
         if (rst_n && bus_req.en)
         begin
            delay = $urandom_range(5, 0);
            repeat (delay) @(negedge clk);
            req = bus_req;
            bus_rsp.rdata = mem[req.addr.raw[`CACHE_ADDR_W-1:`CACHE_OFFSET_W]];
            bus_rsp.ready = 1'b1;
            if (req.wr)
               mem[req.addr.raw[`CACHE_ADDR_W-1:`CACHE_OFFSET_W]] = req.wdata;
            else
               req.wdata = '0;
            // read data on the bus is don't-care
            bus_log.push_back(req);
         end
      end
   end

   // worst access is a write-back plus a fill
   initial
   begin
      wait (table_ready === 1'b1);
      #((tests.size() * 20 + RESET_CYCLES + 4) * CLK_PERIOD);
      $display("timeout: the DUT stopped answering before all tests ran");
      fail_run();
   end

   task automatic fail_run();
      $display("SOME TESTS FAILED");
      $fatal(1);
   endtask

   task automatic check_bit(input string name, input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("error: %s expected %b actual %b", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_line(input string name, input cache_pkg::line_t exp,
                             input cache_pkg::line_t act);
      if (act !== exp)
      begin
         $display("error: %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_bus(input string name, input cache_pkg::bus_req_t exp,
                            input cache_pkg::bus_req_t act);
      if (act !== exp)
      begin
         $display("error: %s expected %h actual %h", name, exp, act);
         fail_run();
      end
   endtask

   function automatic int unsigned line_of(cache_pkg::cache_addr_u a);
      return a.raw[`CACHE_ADDR_W-1:`CACHE_OFFSET_W];
   endfunction

   // mask covers offset up to offset+size-1, full code covers all
   // data lands offset bytes up, zeros below
   function automatic cache_pkg::line_t merge_write(cache_pkg::line_t old, test_t t);
      cache_pkg::line_t res;
      int off;
      int n;
      res = old;
      off = t.addr.f.offset;
      n = (t.size == `CACHE_SIZE_FULL) ? `CACHE_LINE_BYTES : t.size;
      for (int j = 0; j < `CACHE_LINE_BYTES; j++)
      begin
         if (t.size == `CACHE_SIZE_FULL || (j >= off && j < off + n))
            res[8*j +: 8] = (j >= off) ? t.wdata[8*(j-off) +: 8] : 8'h00;
      end
      return res;
   endfunction

   task automatic add_test(input string name, input logic rw, input logic [15:0] addr,
                           input logic [3:0] size, input logic expect_bus);
      test_t t;
      t.name = name;
      t.rw = rw;
      t.addr.raw = addr;
      t.size = size;
      t.wdata = {$urandom, $urandom, $urandom, $urandom};
      t.expect_bus = expect_bus;
      tests.push_back(t);
   endtask

   // address is tag[15:9] index[8:4] offset[3:0]
   task automatic build_table();
      add_test("rd_first_fill", 1'b0, 16'h0230, 4'd0, 1'b1);
      add_test("rd_repeat_hit", 1'b0, 16'h0234, 4'd0, 1'b0);
      add_test("wr_byte_off5", 1'b1, 16'h0235, 4'd1, 1'b0);
      add_test("rd_after_byte", 1'b0, 16'h0230, 4'd0, 1'b0);
      add_test("wr_half_off14", 1'b1, 16'h023e, 4'd2, 1'b0);
      add_test("rd_after_half", 1'b0, 16'h0230, 4'd0, 1'b0);
      // top byte falls off the line
      add_test("wr_word_off13", 1'b1, 16'h023d, 4'd4, 1'b0);
      add_test("rd_after_word", 1'b0, 16'h0230, 4'd0, 1'b0);
      add_test("wr_dword_off8", 1'b1, 16'h0238, 4'd8, 1'b0);
      add_test("rd_after_dword", 1'b0, 16'h0230, 4'd0, 1'b0);
      add_test("wr_line_full", 1'b1, 16'h0230, 4'd15, 1'b0);
      add_test("rd_after_line", 1'b0, 16'h0230, 4'd0, 1'b0);
      add_test("wr_dword_off3", 1'b1, 16'h0233, 4'd8, 1'b0);
      add_test("rd_after_off3", 1'b0, 16'h0230, 4'd0, 1'b0);
      // same index, tag 5 pushes tag 1 out
      add_test("rd_evict_tag1", 1'b0, 16'h0a30, 4'd0, 1'b1);
      add_test("rd_old_tag1", 1'b0, 16'h0230, 4'd0, 1'b1);
      add_test("wr_miss_fill", 1'b1, 16'h0474, 4'd8, 1'b1);
      add_test("rd_after_miss", 1'b0, 16'h0470, 4'd0, 1'b0);
      add_test("wr_miss_evict", 1'b1, 16'h1272, 4'd4, 1'b1);
      add_test("rd_after_evict", 1'b0, 16'h1270, 4'd0, 1'b0);
      add_test("rd_written_back", 1'b0, 16'h0474, 4'd0, 1'b1);
      add_test("rd_top_fill", 1'b0, 16'hfff0, 4'd0, 1'b1);
      add_test("rd_top_hit", 1'b0, 16'hfff8, 4'd0, 1'b0);
   endtask

   task automatic run_test(input test_t t);
      cache_pkg::bus_req_t exp_bus;
      int unsigned idx;
      logic evict_exp;
      int n_exp;
      idx = t.addr.f.index;
      evict_exp = ref_valid[idx] && (ref_tag[idx] != t.addr.f.tag);
      n_exp = int'(evict_exp) + int'(t.expect_bus);
      cpu_req.enable = 1'b1;
      cpu_req.rw = t.rw;
      cpu_req.address = t.addr;
      cpu_req.size = t.size;
      cpu_req.wdata = t.wdata;
      if (!t.expect_bus)
      begin
         // hit, ready exactly two edges after enable is sampled
         @(negedge clk);
         check_bit({t.name, " ready one edge after enable"}, 1'b0, ready);
         @(negedge clk);
         check_bit({t.name, " ready two edges after enable"}, 1'b1, ready);
      end
      else
      begin
         do
            @(negedge clk);
         while (ready !== 1'b1);
      end
      if (!t.rw)
         check_line(t.name, shadow[line_of(t.addr)], rdata);
      // rest of the request held over the edge leaving the hit state
      cpu_req.enable = 1'b0;
      @(negedge clk);
      check_bit({t.name, " bus transfer count matches"}, 1'b1,
                logic'(bus_log.size() == n_exp));
      if (evict_exp)
      begin
         exp_bus.en = 1'b1;
         exp_bus.wr = 1'b1;
         exp_bus.addr.raw = {ref_tag[idx], t.addr.f.index, 4'h0};
         exp_bus.wdata = shadow[line_of(exp_bus.addr)];
         check_bus({t.name, " write-back"}, exp_bus, bus_log.pop_front());
      end
      if (t.expect_bus)
      begin
         exp_bus.en = 1'b1;
         exp_bus.wr = 1'b0;
         exp_bus.addr.raw = {t.addr.raw[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], 4'h0};
         exp_bus.wdata = '0;
         check_bus({t.name, " fill"}, exp_bus, bus_log.pop_front());
      end
      ref_valid[idx] = 1'b1;
      ref_tag[idx] = t.addr.f.tag;
      if (t.rw)
         shadow[line_of(t.addr)] = merge_write(shadow[line_of(t.addr)], t);
   endtask

   initial
   begin
      void'($urandom(30650));
      rst_n = 1'b0;
      cpu_req = '0;
      for (int i = 0; i < MEM_LINES; i++)
      begin
         mem[i] = {$urandom, $urandom, $urandom, $urandom};
         shadow[i] = mem[i];
      end
      for (int i = 0; i < `CACHE_LINES; i++)
         ref_valid[i] = 1'b0;
      build_table();
      table_ready = 1'b1;
      // quiet outputs all through reset
      repeat (RESET_CYCLES)
      begin
         @(negedge clk);
         check_bit("ready in reset", 1'b0, ready);
         check_bit("bus enable in reset", 1'b0, bus_req.en);
      end
      rst_n = 1'b1;
      repeat (2)
      begin
         @(negedge clk);
         check_bit("ready while idle", 1'b0, ready);
         check_bit("bus enable while idle", 1'b0, bus_req.en);
      end
      foreach (tests[i])
         run_test(tests[i]);
      $display("ALL TESTS PASSED");
      $finish;
   end

endmodule

// File: dv/cache_props.sv
module cache_props (
   input logic                clk,
   input logic                rst_n,
   input logic                ready,
   input logic                tag_wr,
   input logic                hit_wr,
   input logic                fill_wr,
   input cache_pkg::bus_req_t bus_req,
   input cache_pkg::bus_rsp_t bus_rsp
);
   timeunit 1ns;
   timeprecision 1ps;

   // hit states always fall back to idle
   ready_one_cycle: assert property (@(posedge clk) disable iff (!rst_n)
      ready |=> !ready)
      else $error("ready stayed high for more than one cycle");

   // request frozen until memory answers
   bus_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
      bus_req.en && !bus_rsp.ready |=> $stable(bus_req))
      else $error("bus request changed while waiting for memory");

   // after a fill the bus drops as ready rises
   fill_hands_over: assert property (@(posedge clk) disable iff (!rst_n)
      bus_req.en && !bus_req.wr && bus_rsp.ready |=> $rose(ready) && $fell(bus_req.en))
      else $error("ready did not rise as the bus dropped after a fill");

   // one reset edge needed before the state is known
   quiet_in_reset: assert property (@(posedge clk)
      !rst_n ##1 !rst_n |-> !ready && !bus_req.en && !tag_wr && !hit_wr && !fill_wr)
      else $error("control output active during reset");

endmodule

bind cache_top cache_props u_props (
   .clk     (clk),
   .rst_n   (rst_n),
   .ready   (ready),
   .tag_wr  (tag_wr),
   .hit_wr  (hit_wr),
   .fill_wr (fill_wr),
   .bus_req (bus_req),
   .bus_rsp (bus_rsp)
);

// File: logic/cache_top.sv
`include "cache_config.svh"

module cache_top (
   input  logic               clk,
   input  logic               rst_n,
   input  cache_pkg::cpu_req_t cpu_req,
   output logic               ready,
   output cache_pkg::line_t   rdata,
   output cache_pkg::bus_req_t bus_req,
   input  cache_pkg::bus_rsp_t bus_rsp
);

   // lookup results
   logic hit;
   logic evict;
   logic [`CACHE_TAG_W-1:0] victim_tag;
   // write strobes from the fsm
   logic tag_wr;
   logic hit_wr;
   logic fill_wr;
   // aligned processor write
   cache_pkg::byte_mask_t wr_mask;
   cache_pkg::line_t wdata_shifted;
   // line at the current index
   cache_pkg::line_t line;

   cache_ctrl u_ctrl (
      .clk        (clk),
      .rst_n      (rst_n),
      .enable     (cpu_req.enable),
      .rw         (cpu_req.rw),
      .address    (cpu_req.address),
      .hit        (hit),
      .evict      (evict),
      .victim_tag (victim_tag),
      .line       (line),
      .bus_ready  (bus_rsp.ready),
      .ready      (ready),
      .tag_wr     (tag_wr),
      .hit_wr     (hit_wr),
      .fill_wr    (fill_wr),
      .bus_req    (bus_req)
   );

   tag_store u_tags (
      .clk        (clk),
      .rst_n      (rst_n),
      .address    (cpu_req.address),
      .tag_wr     (tag_wr),
      .hit        (hit),
      .evict      (evict),
      .victim_tag (victim_tag)
   );

   write_align u_align (
      .size          (cpu_req.size),
      .offset        (cpu_req.address.f.offset),
      .wdata         (cpu_req.wdata),
      .wr_mask       (wr_mask),
      .wdata_shifted (wdata_shifted)
   );

   data_store u_data (
      .clk           (clk),
      .index         (cpu_req.address.f.index),
      .hit_wr        (hit_wr),
      .fill_wr       (fill_wr),
      .wr_mask       (wr_mask),
      .wdata_shifted (wdata_shifted),
      .fill_data     (bus_rsp.rdata),
      .line          (line)
   );

   // whole line goes back to the processor
   assign rdata = line;

endmodule

// File: logic/cache_ctrl.sv
`include "cache_config.svh"

module cache_ctrl (
   input  logic                    clk,
   input  logic                    rst_n,
   input  logic                    enable,
   input  logic                    rw,
   input  cache_pkg::cache_addr_u  address,
   input  logic                    hit,
   input  logic                    evict,
   input  logic [`CACHE_TAG_W-1:0] victim_tag,
   input  cache_pkg::line_t        line,
   input  logic                    bus_ready,
   output logic                    ready,
   output logic                    tag_wr,
   output logic                    hit_wr,
   output logic                    fill_wr,
   output cache_pkg::bus_req_t     bus_req
);

   cache_pkg::state_t state;
   cache_pkg::state_t state_nxt;
   cache_pkg::cache_addr_u bus_addr;
   logic missing;
   logic evicting;

   always_ff @(posedge clk)
   begin
      if (!rst_n)
         state <= cache_pkg::ST_IDLE;
      else
         state <= state_nxt;
   end

   // transitions, read and write sides mirror each other
   always_comb
   begin
      state_nxt = state;
      case (state)
         cache_pkg::ST_IDLE:
         begin
            if (enable)
               state_nxt = rw ? cache_pkg::ST_WR : cache_pkg::ST_RD;
         end
         cache_pkg::ST_RD:
         begin
            if (hit)
               state_nxt = cache_pkg::ST_RD_HIT;
            else
               state_nxt = evict ? cache_pkg::ST_RD_EVICT : cache_pkg::ST_RD_MISS;
         end
         cache_pkg::ST_WR:
         begin
            if (hit)
               state_nxt = cache_pkg::ST_WR_HIT;
            else
               state_nxt = evict ? cache_pkg::ST_WR_EVICT : cache_pkg::ST_WR_MISS;
         end
         // wait on the bus pulse
         cache_pkg::ST_RD_MISS:
         begin
            if (bus_ready)
               state_nxt = cache_pkg::ST_RD_HIT;
         end
         cache_pkg::ST_WR_MISS:
         begin
            if (bus_ready)
               state_nxt = cache_pkg::ST_WR_HIT;
         end
         // write-back done, go fetch the new line
         cache_pkg::ST_RD_EVICT:
         begin
            if (bus_ready)
               state_nxt = cache_pkg::ST_RD_MISS;
         end
         cache_pkg::ST_WR_EVICT:
         begin
            if (bus_ready)
               state_nxt = cache_pkg::ST_WR_MISS;
         end
         default: state_nxt = cache_pkg::ST_IDLE;
      endcase
   end

   // strobes straight off the state
   assign missing  = (state == cache_pkg::ST_RD_MISS) || (state == cache_pkg::ST_WR_MISS);
   assign evicting = (state == cache_pkg::ST_RD_EVICT) || (state == cache_pkg::ST_WR_EVICT);
   assign ready    = (state == cache_pkg::ST_RD_HIT) || (state == cache_pkg::ST_WR_HIT);
   // tag lands as the access completes
   assign tag_wr   = ready;
   assign hit_wr   = state == cache_pkg::ST_WR_HIT;
   assign fill_wr  = missing && bus_ready;

   // line address, victim tag swapped in on write-back
   always_comb
   begin
      bus_addr.raw = {address.raw[`CACHE_ADDR_W-1:`CACHE_OFFSET_W], {`CACHE_OFFSET_W{1'b0}}};
      if (evicting)
         bus_addr.f.tag = victim_tag;
   end

   assign bus_req.en    = missing || evicting;
   assign bus_req.wr    = evicting;
   assign bus_req.addr  = bus_addr;
   // only sampled by memory on a write-back
   assign bus_req.wdata = line;

endmodule

// File: logic/data_store.sv
`include "cache_config.svh"

module data_store (
   input  logic                      clk,
   input  logic [`CACHE_INDEX_W-1:0] index,
   input  logic                      hit_wr,
   input  logic                      fill_wr,
   input  cache_pkg::byte_mask_t     wr_mask,
   input  cache_pkg::line_t          wdata_shifted,
   input  cache_pkg::line_t          fill_data,
   output cache_pkg::line_t          line
);

   // line array, contents only trusted under a valid tag
   cache_pkg::line_t lines [`CACHE_LINES];

   // fill replaces the whole line
   // processor write merges masked bytes
   always_ff @(posedge clk)
   begin
      if (fill_wr)
      begin
         lines[index] <= fill_data;
      end
      else if (hit_wr)
      begin
         for (int b = 0; b < `CACHE_LINE_BYTES; b++)
         begin
            if (wr_mask[b])
               lines[index][8*b +: 8] <= wdata_shifted[8*b +: 8];
         end
      end
   end

   // async read of the indexed line
   assign line = lines[index];

endmodule

// File: logic/tag_store.sv
`include "cache_config.svh"

module tag_store (
   input  logic                    clk,
   input  logic                    rst_n,
   input  cache_pkg::cache_addr_u  address,
   input  logic                    tag_wr,
   output logic                    hit,
   output logic                    evict,
   output logic [`CACHE_TAG_W-1:0] victim_tag
);

   // one tag per line
   logic [`CACHE_TAG_W-1:0] tags [`CACHE_LINES];
   // valid bit per line
   logic [`CACHE_LINES-1:0] valid;
   logic line_valid;
   logic tag_match;

   always_ff @(posedge clk)
   begin
      if (tag_wr)
         tags[address.f.index] <= address.f.tag;
   end

   // lines never invalidate after fill
   always_ff @(posedge clk)
   begin
      if (!rst_n)
         valid <= '0;
      else if (tag_wr)
         valid[address.f.index] <= 1'b1;
   end

   // async lookup at current index
   assign victim_tag = tags[address.f.index];
   assign line_valid = valid[address.f.index];
   assign tag_match  = victim_tag == address.f.tag;

   assign hit = line_valid && tag_match;
   // valid line owned by another tag, write back first
   assign evict = line_valid && !tag_match;

endmodule

// File: logic/write_align.sv
`include "cache_config.svh"

module write_align (
   input  logic [3:0]                 size,
   input  logic [`CACHE_OFFSET_W-1:0] offset,
   input  cache_pkg::line_t           wdata,
   output cache_pkg::byte_mask_t      wr_mask,
   output cache_pkg::line_t           wdata_shifted
);

   // low-byte mask before alignment
   cache_pkg::byte_mask_t base_mask;
   cache_pkg::byte_mask_t shifted_mask;

   // 1 -> 0001, 2 -> 0003, 4 -> 000f, 8 -> 00ff
   always_comb
   begin
      base_mask      = '0;
      base_mask[0]   = 1'b1;
      base_mask[1]   = |size[3:1];
      base_mask[3:2] = {2{|size[3:2]}};
      base_mask[7:4] = {4{size[3]}};
   end

   // bytes past the end of the line drop off
   assign shifted_mask = base_mask << offset;

   // full-line code ignores offset
   assign wr_mask = (size == 4'(`CACHE_SIZE_FULL)) ? '1 : shifted_mask;

   // byte shift, zero fill from the bottom
   assign wdata_shifted = wdata << {offset, 3'b000};

endmodule

// File: logic/cache_pkg.sv
`include "cache_config.svh"

package cache_pkg;

   // one full cache line
   typedef logic [8*`CACHE_LINE_BYTES-1:0] line_t;

   // one write enable per byte of a line
   typedef logic [`CACHE_LINE_BYTES-1:0] byte_mask_t;

   // field view of an address, msb first
   typedef struct packed {
      logic [`CACHE_TAG_W-1:0]    tag;
      logic [`CACHE_INDEX_W-1:0]  index;
      logic [`CACHE_OFFSET_W-1:0] offset;
   } addr_fields_t;

   // raw word for the bus, fields for lookup and alignment
   typedef union packed {
      logic [`CACHE_ADDR_W-1:0] raw;
      addr_fields_t             f;
   } cache_addr_u;

   // processor side request
   typedef struct packed {
      logic        enable;
      // 1 = write
      logic        rw;
      cache_addr_u address;
      // 1, 2, 4, 8 or full line code
      logic [3:0]  size;
      line_t       wdata;
   } cpu_req_t;

   // line-wide memory bus, level enable
   typedef struct packed {
      logic        en;
      logic        wr;
      cache_addr_u addr;
      line_t       wdata;
   } bus_req_t;

   // one-cycle ready pulse, rdata valid with it
   typedef struct packed {
      logic  ready;
      line_t rdata;
   } bus_rsp_t;

   // one-hot controller states
   typedef enum logic [8:0] {
      ST_IDLE     = 9'b0_0000_0001,
      ST_RD       = 9'b0_0000_0010,
      ST_RD_HIT   = 9'b0_0000_0100,
      ST_RD_MISS  = 9'b0_0000_1000,
      ST_RD_EVICT = 9'b0_0001_0000,
      ST_WR       = 9'b0_0010_0000,
      ST_WR_HIT   = 9'b0_0100_0000,
      ST_WR_MISS  = 9'b0_1000_0000,
      ST_WR_EVICT = 9'b1_0000_0000
   } state_t;

endpackage

// File: logic/cache_config.svh
`ifndef CACHE_CONFIG_SVH
`define CACHE_CONFIG_SVH

// geometry of the direct-mapped cache
`define CACHE_LINES 32
// bytes per line, line width is 8x this
`define CACHE_LINE_BYTES 16

// address split, tag | index | offset
`define CACHE_ADDR_W 16
`define CACHE_TAG_W 7
`define CACHE_INDEX_W 5
`define CACHE_OFFSET_W 4

// size code for a whole-line write
`define CACHE_SIZE_FULL 15

`endif
